// File: Makefile
# Verilator build and run for the TLB testbench

VERILATOR ?= verilator
TOP ?= tlb_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= All tests passed!

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := tlb_params.svh
TRACE := tlb_trace.txt
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(TRACE)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sources.f
+incdir+.
tlb_pkg.sv
tlbEntryRam.sv
tlbReplaceCounter.sv
tlbLookup.sv
tlbCmdFsm.sv
tlbTop.sv
tlb_assertions.sv
tlb_tb.sv

// File: tlbCmdFsm.sv
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlbCmdFsm (
	input wire clk,
	input wire rstN_i,
	input wire ld_i,
	input wire tlbPkg::tlbCmd_t cmd_i,
	input wire tlbPkg::tlbEntry_t [`TLB_WAYS-1:0] cmdEntries_i,
	input wire tlbPkg::ppn_t [`TLB_WAYS-1:0] cmdPpns_i,
	input wire missEvent_i,
	input wire [`TLB_VABITS-1:0] vaddr_i,
	input wire [`TLB_WAYBITS-1:0] randomWay_i,
	input wire [`TLB_WAYBITS-1:0] wired_i,
	output logic done_o,
	output logic idle_o,
	output logic [`TLB_VABITS-1:0] dato_o,
	output logic enabled_o,
	output tlbPkg::tlbWrite_t wr_o,
	output logic invAll_o,
	output logic [`TLB_SETBITS-1:0] rdSet_o,
	output logic wiredWe_o,
	output logic randomWe_o,
	output logic [`TLB_WAYBITS-1:0] wrData_o
);

	typedef enum logic [1:0] {IDLE, ONE, TWO} state_e;

	state_e state;
	tlbPkg::tlbCmd_t cmdQ;
	// Holding registers, VirtPage is the entry tag plus hSet
	tlbPkg::tlbEntry_t hEntry;
	logic [`TLB_SETBITS-1:0] hSet;
	tlbPkg::ppn_t hPpn;
	tlbPkg::vpn_t hVpn;
	logic [`TLB_WAYBITS-1:0] indexWay;
	logic indexMiss;
	logic [`TLB_WAYBITS-1:0] rndWay;
	logic [`TLB_VABITS-1:0] missAdr;
	logic isWrReg;
	logic probeHit;
	logic [`TLB_WAYBITS-1:0] probeWay;

	assign hVpn = {hEntry.tag, hSet};
	assign isWrReg = (state == ONE) && (cmdQ.op == tlbPkg::WRREG);

	// ==========================================================================
	// Sequencing
	// ==========================================================================
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
					if (ld_i)
						state <= ONE;
				ONE:
					state <= TWO;
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == IDLE) && ld_i)
			cmdQ <= cmd_i;
		// Random way is frozen here for a WRRND in TWO
		if (state == ONE)
			rndWay <= randomWay_i;
	end

	// ==========================================================================
	// Holding registers
	// ==========================================================================
	always_ff @(posedge clk)
	begin
		if (isWrReg)
		begin
			case (cmdQ.regno)
				tlbPkg::VIRTPAGE:
				begin
					hEntry.tag <= cmdQ.dati[`TLB_VPNBITS-1:`TLB_SETBITS];
					hSet <= cmdQ.dati[`TLB_SETBITS-1:0];
				end
				tlbPkg::PHYSPAGE:
					hPpn <= cmdQ.dati[`TLB_VPNBITS-1:0];
				tlbPkg::ATTR:
				begin
					hEntry.x <= cmdQ.dati[0];
					hEntry.w <= cmdQ.dati[1];
					hEntry.r <= cmdQ.dati[2];
					hEntry.uncached <= cmdQ.dati[3];
					hEntry.glob <= cmdQ.dati[4];
					hEntry.asid <= cmdQ.dati[8 +: `TLB_ASIDBITS];
					hEntry.valid <= |cmdQ.dati[2:0];
				end
				default:
					;
			endcase
		end
		else if ((state == TWO) && (cmdQ.op == tlbPkg::READ))
		begin
			hEntry <= cmdEntries_i[indexWay];
			hPpn <= cmdPpns_i[indexWay];
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			indexWay <= '0;
			indexMiss <= 1'b0;
			enabled_o <= 1'b0;
		end
		else if (state == ONE)
		begin
			case (cmdQ.op)
				tlbPkg::WRREG:
					if (cmdQ.regno == tlbPkg::INDEX)
					begin
						indexWay <= cmdQ.dati[`TLB_WAYBITS-1:0];
						indexMiss <= cmdQ.dati[`TLB_VABITS-1];
					end
				tlbPkg::ENABLE:
					enabled_o <= 1'b1;
				tlbPkg::DISABLE:
					enabled_o <= 1'b0;
				default:
					;
			endcase
		end
		else if ((state == TWO) && (cmdQ.op == tlbPkg::PROBE))
		begin
			indexMiss <= !probeHit;
			if (probeHit)
				indexWay <= probeWay;
		end
	end

	// First miss only, software clears it by writing zero
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
			missAdr <= '0;
		else if (isWrReg && (cmdQ.regno == tlbPkg::MISSADR))
			missAdr <= cmdQ.dati;
		else if (missEvent_i && (missAdr == '0))
			missAdr <= vaddr_i;
	end

	// Probe the set of the holding page with the holding ASID
	always_comb
	begin
		probeHit = 1'b0;
		probeWay = '0;
		for (int w = `TLB_WAYS - 1; w >= 0; w--)
		begin
			if (tlbPkg::entryMatches(cmdEntries_i[w], hVpn, hEntry.asid))
			begin
				probeHit = 1'b1;
				probeWay = `TLB_WAYBITS'(w);
			end
		end
	end

	// ==========================================================================
	// Outputs
	// ==========================================================================
	assign done_o = (state == TWO);
	assign idle_o = (state == IDLE);
	assign rdSet_o = hSet;
	assign invAll_o = (state == ONE) && (cmdQ.op == tlbPkg::INVALL);
	assign wiredWe_o = isWrReg && (cmdQ.regno == tlbPkg::WIRED);
	assign randomWe_o = isWrReg && (cmdQ.regno == tlbPkg::RANDOM);
	assign wrData_o = cmdQ.dati[`TLB_WAYBITS-1:0];

	always_comb
	begin
		wr_o.we = (state == TWO)
			&& ((cmdQ.op == tlbPkg::WRIDX) || (cmdQ.op == tlbPkg::WRRND));
		wr_o.way = (cmdQ.op == tlbPkg::WRRND) ? rndWay : indexWay;
		wr_o.set = hSet;
		wr_o.entry = hEntry;
		wr_o.ppn = hPpn;
	end

	always_comb
	begin
		dato_o = '0;
		case (cmdQ.regno)
			tlbPkg::WIRED:
				dato_o[`TLB_WAYBITS-1:0] = wired_i;
			tlbPkg::INDEX:
			begin
				dato_o[`TLB_VABITS-1] = indexMiss;
				dato_o[`TLB_WAYBITS-1:0] = indexWay;
			end
			tlbPkg::RANDOM:
				dato_o[`TLB_WAYBITS-1:0] = randomWay_i;
			tlbPkg::VIRTPAGE:
				dato_o[`TLB_VPNBITS-1:0] = hVpn;
			tlbPkg::PHYSPAGE:
				dato_o[`TLB_VPNBITS-1:0] = hPpn;
			tlbPkg::ATTR:
			begin
				dato_o[4:0] = {hEntry.glob, hEntry.uncached, hEntry.r, hEntry.w, hEntry.x};
				dato_o[8 +: `TLB_ASIDBITS] = hEntry.asid;
			end
			tlbPkg::MISSADR:
				dato_o = missAdr;
			default:
				;
		endcase
	end

endmodule

`default_nettype wire

// File: tlbEntryRam.sv
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

// One way of storage, indexed by set
// Port 0 serves the lookup, port 1 the command side
module tlbEntryRam #(
	parameter type payload_t = logic,
	parameter int depth = `TLB_SETS,
	localparam int addrBits = $clog2(depth)
) (
	input wire clk,
	input wire we_i,
	input wire [addrBits-1:0] wa_i,
	input wire payload_t data_i,
	input wire [addrBits-1:0] ra0_i,
	input wire [addrBits-1:0] ra1_i,
	output payload_t rd0_o,
	output payload_t rd1_o
);

	payload_t mem [depth];

	always_ff @(posedge clk)
	begin
		if (we_i)
			mem[wa_i] <= data_i;
	end

	// Asynchronous reads, distributed RAM style
	assign rd0_o = mem[ra0_i];
	assign rd1_o = mem[ra1_i];

endmodule

`default_nettype wire

// File: tlbLookup.sv
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlbLookup (
	input wire clk,
	input wire rstN_i,
	input wire enabled_i,
	input wire [1:0] ol_i,
	input wire [`TLB_ASIDBITS-1:0] asid_i,
	input wire tlbPkg::memReq_t req_i,
	input wire tlbPkg::tlbWrite_t wr_i,
	input wire invAll_i,
	input wire [`TLB_SETBITS-1:0] rdSet_i,
	output tlbPkg::tlbEntry_t [`TLB_WAYS-1:0] cmdEntries_o,
	output tlbPkg::ppn_t [`TLB_WAYS-1:0] cmdPpns_o,
	output logic missEvent_o,
	output tlbPkg::memResp_t resp_o
);

	tlbPkg::vpn_t reqVpn;
	logic [`TLB_SETBITS-1:0] reqSet;
	tlbPkg::tlbEntry_t [`TLB_WAYS-1:0] lookRaw;
	tlbPkg::tlbEntry_t [`TLB_WAYS-1:0] lookEntry;
	tlbPkg::tlbEntry_t [`TLB_WAYS-1:0] cmdRaw;
	tlbPkg::ppn_t [`TLB_WAYS-1:0] lookPpn;
	logic [`TLB_WAYS-1:0][`TLB_SETS-1:0] validQ;
	logic hit;
	logic [`TLB_WAYBITS-1:0] hitWay;
	tlbPkg::tlbEntry_t hitEntry;
	tlbPkg::ppn_t hitPpn;
	logic translate;
	logic miss;
	logic cycQ, weQ, missQ, rdvQ, wrvQ, exvQ;
	logic uncachedQ;
	logic [`TLB_VABITS-1:0] padrQ;

	assign reqVpn = req_i.vaddr[`TLB_VABITS-1:`TLB_PAGEBITS];
	assign reqSet = reqVpn[`TLB_SETBITS-1:0];

	// ==========================================================================
	// Way storage
	// ==========================================================================
	for (genvar w = 0; w < `TLB_WAYS; w++)
	begin : gWay
		logic wayWe;

		assign wayWe = wr_i.we && (wr_i.way == `TLB_WAYBITS'(w));

		tlbEntryRam #(.payload_t(tlbPkg::tlbEntry_t)) entryRam (
			.clk(clk), .we_i(wayWe), .wa_i(wr_i.set), .data_i(wr_i.entry),
			.ra0_i(reqSet), .ra1_i(rdSet_i), .rd0_o(lookRaw[w]), .rd1_o(cmdRaw[w])
		);

		tlbEntryRam #(.payload_t(tlbPkg::ppn_t)) ppnRam (
			.clk(clk), .we_i(wayWe), .wa_i(wr_i.set), .data_i(wr_i.ppn),
			.ra0_i(reqSet), .ra1_i(rdSet_i), .rd0_o(lookPpn[w]), .rd1_o(cmdPpns_o[w])
		);
	end

	// Valid bits live in flops so they can be cleared in one go
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
			validQ <= '0;
		else if (invAll_i)
			validQ <= '0;
		else if (wr_i.we)
			validQ[wr_i.way][wr_i.set] <= wr_i.entry.valid;
	end

	always_comb
	begin
		for (int w = 0; w < `TLB_WAYS; w++)
		begin
			lookEntry[w] = lookRaw[w];
			lookEntry[w].valid = validQ[w][reqSet];
			cmdEntries_o[w] = cmdRaw[w];
			cmdEntries_o[w].valid = validQ[w][rdSet_i];
		end
	end

	// ==========================================================================
	// Hit detection, lowest matching way wins
	// ==========================================================================
	always_comb
	begin
		hit = 1'b0;
		hitWay = '0;
		for (int w = `TLB_WAYS - 1; w >= 0; w--)
		begin
			if (tlbPkg::entryMatches(lookEntry[w], reqVpn, asid_i))
			begin
				hit = 1'b1;
				hitWay = `TLB_WAYBITS'(w);
			end
		end
	end

	assign hitEntry = lookEntry[hitWay];
	assign hitPpn = lookPpn[hitWay];

	// Bypass when disabled, at level 0 or in the unmapped region
	assign translate = enabled_i && (ol_i != 2'b00)
		&& (req_i.vaddr[`TLB_VABITS-1 -: 4] != `TLB_UNMAPPED_NIB);
	assign miss = translate && !hit;
	assign missEvent_o = miss && req_i.cyc;

	always_ff @(posedge clk)
	begin
		if (!rstN_i)
		begin
			cycQ <= 1'b0;
			weQ <= 1'b0;
			missQ <= 1'b0;
			rdvQ <= 1'b0;
			wrvQ <= 1'b0;
			exvQ <= 1'b0;
		end
		else
		begin
			cycQ <= req_i.cyc && !miss;
			weQ <= req_i.we && (!translate || (hit && hitEntry.w));
			missQ <= missEvent_o;
			rdvQ <= req_i.cyc && translate && hit && !req_i.we && !req_i.icl && !hitEntry.r;
			wrvQ <= req_i.cyc && translate && hit && req_i.we && !hitEntry.w;
			exvQ <= req_i.cyc && translate && hit && req_i.icl && !hitEntry.x;
		end
	end

	// Address keeps its page offset, a miss gets the miss page
	always_ff @(posedge clk)
	begin
		uncachedQ <= translate && hit && hitEntry.uncached;
		if (!translate)
			padrQ <= req_i.vaddr;
		else if (miss)
			padrQ <= {`TLB_MISS_PAGE, req_i.vaddr[`TLB_PAGEBITS-1:0]};
		else
			padrQ <= {hitPpn, req_i.vaddr[`TLB_PAGEBITS-1:0]};
	end

	always_comb
	begin
		resp_o.cyc = cycQ;
		resp_o.we = weQ;
		resp_o.padr = padrQ;
		resp_o.miss = missQ;
		resp_o.rdv = rdvQ;
		resp_o.wrv = wrvQ;
		resp_o.exv = exvQ;
		resp_o.uncached = uncachedQ;
	end

endmodule

`default_nettype wire

// File: tlbReplaceCounter.sv
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlbReplaceCounter (
	input wire clk,
	input wire rstN_i,
	input wire wiredWe_i,
	input wire randomWe_i,
	input wire [`TLB_WAYBITS-1:0] data_i,
	output logic [`TLB_WAYBITS-1:0] random_o,
	output logic [`TLB_WAYBITS-1:0] wired_o
);

	localparam logic [`TLB_WAYBITS-1:0] topWay = `TLB_WAYBITS'(`TLB_WAYS - 1);

	// Ways below Wired are locked against random replacement
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
			wired_o <= '0;
		else if (wiredWe_i)
			wired_o <= data_i;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN_i)
			random_o <= topWay;
		else if (randomWe_i)
			random_o <= data_i;
		// Wrap back to the top once the wired limit is reached
		else if (random_o <= wired_o)
			random_o <= topWay;
		else
			random_o <= random_o - 1'b1;
	end

endmodule

`default_nettype wire

// File: tlbTop.sv
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlbTop (
	input wire clk,
	input wire rstN_i,
	input wire ld_i,
	input wire tlbPkg::tlbCmd_t cmd_i,
	input wire [1:0] ol_i,
	input wire [`TLB_ASIDBITS-1:0] asid_i,
	input wire tlbPkg::memReq_t req_i,
	output logic done_o,
	output logic idle_o,
	output logic [`TLB_VABITS-1:0] dato_o,
	output tlbPkg::memResp_t resp_o
);

	tlbPkg::tlbWrite_t wr;
	logic invAll;
	logic enabled;
	logic [`TLB_SETBITS-1:0] rdSet;
	logic wiredWe;
	logic randomWe;
	logic [`TLB_WAYBITS-1:0] wrData;
	logic [`TLB_WAYBITS-1:0] randomWay;
	logic [`TLB_WAYBITS-1:0] wired;
	tlbPkg::tlbEntry_t [`TLB_WAYS-1:0] cmdEntries;
	tlbPkg::ppn_t [`TLB_WAYS-1:0] cmdPpns;
	logic missEvent;

	// Command side
	tlbCmdFsm cmdFsm (
		.clk(clk), .rstN_i(rstN_i), .ld_i(ld_i), .cmd_i(cmd_i),
		.cmdEntries_i(cmdEntries), .cmdPpns_i(cmdPpns),
		.missEvent_i(missEvent), .vaddr_i(req_i.vaddr),
		.randomWay_i(randomWay), .wired_i(wired),
		.done_o(done_o), .idle_o(idle_o), .dato_o(dato_o),
		.enabled_o(enabled), .wr_o(wr), .invAll_o(invAll), .rdSet_o(rdSet),
		.wiredWe_o(wiredWe), .randomWe_o(randomWe), .wrData_o(wrData)
	);

	tlbReplaceCounter replaceCounter (
		.clk(clk), .rstN_i(rstN_i),
		.wiredWe_i(wiredWe), .randomWe_i(randomWe), .data_i(wrData),
		.random_o(randomWay), .wired_o(wired)
	);

	// Translation side
	tlbLookup lookup (
		.clk(clk), .rstN_i(rstN_i), .enabled_i(enabled),
		.ol_i(ol_i), .asid_i(asid_i), .req_i(req_i),
		.wr_i(wr), .invAll_i(invAll), .rdSet_i(rdSet),
		.cmdEntries_o(cmdEntries), .cmdPpns_o(cmdPpns),
		.missEvent_o(missEvent), .resp_o(resp_o)
	);

endmodule

`default_nettype wire

// File: tlb_assertions.sv
`timescale 1ns/1ns
`default_nettype none

// Protocol and reset checks on the TLB top level
module tlbAssertions (
	input wire clk,
	input wire rstN_i,
	input wire ld_i,
	input wire idle_i,
	input wire done_i,
	input wire tlbPkg::memResp_t resp_i
);

	// ==========================================================================
	// Command port
	// ==========================================================================
	doneAfterLoad: assert property (@(posedge clk) disable iff (!rstN_i)
		$past(ld_i, 2) |-> done_i)
		else $error("done_o missing two cycles after ld_i");

	doneOnlyAfterLoad: assert property (@(posedge clk) disable iff (!rstN_i)
		done_i |-> $past(ld_i, 2))
		else $error("done_o without a load two cycles before");

	donePulse: assert property (@(posedge clk) disable iff (!rstN_i)
		done_i |=> !done_i)
		else $error("done_o held longer than one cycle");

	loadWhenIdle: assert property (@(posedge clk) disable iff (!rstN_i)
		ld_i |-> idle_i)
		else $error("ld_i raised while the command FSM was busy");

	// Translation side
	missDropsCycle: assert property (@(posedge clk) disable iff (!rstN_i)
		!(resp_i.cyc && resp_i.miss))
		else $error("resp cyc and miss high together");

	resetState: assert property (@(posedge clk)
		!rstN_i |=> !done_i && idle_i && !resp_i.cyc && !resp_i.miss)
		else $error("Outputs not at their reset values");

endmodule

`default_nettype wire

// File: tlb_params.svh
`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// ==========================================================================
// Address and page geometry
// ==========================================================================
`define TLB_VABITS 32
`define TLB_PAGEBITS 12
`define TLB_VPNBITS (`TLB_VABITS - `TLB_PAGEBITS)

// 64 entries as 4 ways of 16 sets, bit counts kept in step by hand
`define TLB_WAYS 4
`define TLB_WAYBITS 2
`define TLB_SETS 16
`define TLB_SETBITS 4
`define TLB_TAGBITS (`TLB_VPNBITS - `TLB_SETBITS)
`define TLB_ASIDBITS 8

// Top nibble of the untranslated region
`define TLB_UNMAPPED_NIB 4'hF
// Page number driven out on a miss
`define TLB_MISS_PAGE {`TLB_VPNBITS{1'b1}}

`endif

// File: tlb_pkg.sv
`default_nettype none
`include "tlb_params.svh"

package tlbPkg;

	typedef logic [`TLB_VPNBITS-1:0] vpn_t;
	typedef logic [`TLB_VPNBITS-1:0] ppn_t;

	// One way of one set, glob marks an entry shared by all ASIDs
	typedef struct packed {
		logic valid;
		logic glob;
		logic [`TLB_ASIDBITS-1:0] asid;
		logic [`TLB_TAGBITS-1:0] tag;
		logic r;
		logic w;
		logic x;
		logic uncached;
	} tlbEntry_t;

	typedef enum logic [3:0] {
		NOP = 4'd0,
		WRREG = 4'd1,
		RDREG = 4'd2,
		PROBE = 4'd3,
		READ = 4'd4,
		WRIDX = 4'd5,
		WRRND = 4'd6,
		ENABLE = 4'd7,
		DISABLE = 4'd8,
		INVALL = 4'd9
	} tlbOp_e;

	typedef enum logic [2:0] {
		WIRED = 3'd0,
		INDEX = 3'd1,
		RANDOM = 3'd2,
		VIRTPAGE = 3'd3,
		PHYSPAGE = 3'd4,
		ATTR = 3'd5,
		MISSADR = 3'd6
	} tlbReg_e;

	typedef struct packed {
		tlbOp_e op;
		tlbReg_e regno;
		logic [`TLB_VABITS-1:0] dati;
	} tlbCmd_t;

	typedef struct packed {
		logic cyc;
		logic we;
		logic icl;
		logic [`TLB_VABITS-1:0] vaddr;
	} memReq_t;

	typedef struct packed {
		logic cyc;
		logic we;
		logic [`TLB_VABITS-1:0] padr;
		logic miss;
		logic rdv;
		logic wrv;
		logic exv;
		logic uncached;
	} memResp_t;

	// Entry write port from the command side
	typedef struct packed {
		logic we;
		logic [`TLB_WAYBITS-1:0] way;
		logic [`TLB_SETBITS-1:0] set;
		tlbEntry_t entry;
		ppn_t ppn;
	} tlbWrite_t;

	// Tag compare above the set bits, ASID ignored for global entries
	function automatic logic entryMatches(
		tlbEntry_t entry,
		vpn_t vpn,
		logic [`TLB_ASIDBITS-1:0] asid
	);
		return entry.valid && (entry.tag == vpn[`TLB_VPNBITS-1:`TLB_SETBITS])
			&& ((entry.asid == asid) || entry.glob);
	endfunction

endpackage

`default_nettype wire

// File: tlb_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "tlb_params.svh"

module tlb_tb;

	localparam int clkPeriod = 10;
	localparam int resetCycles = 16;
	localparam int doneTimeout = 4;
	// Worst case per trace line, idle gap included
	localparam int stepCycles = 12;

	// One trace line, either a command or an access
	typedef struct packed {
		logic isAccess;
		logic [15:0] lineNo;
		tlbPkg::tlbCmd_t cmd;
		logic [`TLB_VABITS-1:0] expDato;
		logic [1:0] ol;
		logic [`TLB_ASIDBITS-1:0] asid;
		tlbPkg::memReq_t req;
		tlbPkg::memResp_t expResp;
	} traceStep_t;

	logic clk;
	logic rstN;
	logic ld;
	tlbPkg::tlbCmd_t cmd;
	logic [1:0] ol;
	logic [`TLB_ASIDBITS-1:0] asid;
	tlbPkg::memReq_t req;
	logic done;
	logic idle;
	logic [`TLB_VABITS-1:0] dato;
	tlbPkg::memResp_t resp;
	traceStep_t steps[$];
	logic traceLoaded;
	logic [15:0] lfsr;

	tlbTop tlbTop_i (
		.clk(clk), .rstN_i(rstN), .ld_i(ld), .cmd_i(cmd), .ol_i(ol), .asid_i(asid),
		.req_i(req), .done_o(done), .idle_o(idle), .dato_o(dato), .resp_o(resp)
	);

	bind tlbTop tlbAssertions assertions (
		.clk(clk), .rstN_i(rstN_i), .ld_i(ld_i), .idle_i(idle_o),
		.done_i(done_o), .resp_i(resp_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic checkField(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else stopOnError($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
	endtask

	// 16-bit Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] nextLfsr(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		else
			return state >> 1;
	endfunction

	// 0 to 3 idle cycles, one LFSR step per bit
	task automatic waitIdleGap();
		int gap;
		gap = 0;
		for (int b = 0; b < 2; b++)
		begin
			lfsr = nextLfsr(lfsr);
			gap = (gap << 1) | int'(lfsr[0]);
		end
		repeat (gap) @(posedge clk);
	endtask

	// ==========================================================================
	// Trace file
	// ==========================================================================
	task automatic loadTrace();
		int fd;
		int n;
		int lineNo;
		string line;
		logic [31:0] col [0:12];
		traceStep_t step;
		lineNo = 0;
		fd = $fopen("tlb_trace.txt", "r");
		if (fd == 0)
			stopOnError("Could not open tlb_trace.txt");
		while ($fgets(line, fd) != 0)
		begin
			lineNo++;
			if (line.len() > 1 && line.substr(0, 0) != "#")
			begin
				step = '0;
				step.lineNo = 16'(lineNo);
				n = $sscanf(line, "%h", col[0]);
				if (col[0] == 32'd0)
				begin
					n = $sscanf(line, "%h %h %h %h %h", col[0], col[1], col[2], col[3], col[4]);
					if (n != 5)
						stopOnError($sformatf("Bad command on trace line %0d", lineNo));
					step.cmd.op = tlbPkg::tlbOp_e'(col[1][3:0]);
					step.cmd.regno = tlbPkg::tlbReg_e'(col[2][2:0]);
					step.cmd.dati = col[3];
					step.expDato = col[4];
				end
				else
				begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
						col[0], col[1], col[2], col[3], col[4], col[5], col[6],
						col[7], col[8], col[9], col[10], col[11], col[12]);
					if (n != 13)
						stopOnError($sformatf("Bad access on trace line %0d", lineNo));
					step.isAccess = 1'b1;
					step.ol = col[1][1:0];
					step.asid = col[2][`TLB_ASIDBITS-1:0];
					step.req.cyc = col[3][0];
					step.req.we = col[4][0];
					step.req.icl = col[5][0];
					step.req.vaddr = col[6];
					step.expResp.padr = col[7];
					step.expResp.miss = col[8][0];
					step.expResp.rdv = col[9][0];
					step.expResp.wrv = col[10][0];
					step.expResp.exv = col[11][0];
					step.expResp.uncached = col[12][0];
					// A miss drops the cycle, a miss or write violation drops we
					step.expResp.cyc = step.req.cyc && !step.expResp.miss;
					step.expResp.we = step.req.we && !step.expResp.miss && !step.expResp.wrv;
				end
				steps.push_back(step);
			end
		end
		$fclose(fd);
		traceLoaded = 1'b1;
	endtask

	task automatic runCommand(input traceStep_t s);
		int waited;
		waited = 0;
		@(posedge clk);
		ld <= 1'b1;
		cmd <= s.cmd;
		@(posedge clk);
		ld <= 1'b0;
		@(negedge clk);
		while (!done && waited < doneTimeout)
		begin
			@(negedge clk);
			waited++;
		end
		if (!done)
			stopOnError($sformatf("done_o never came for the command on trace line %0d",
				s.lineNo));
		else
		begin
			checkField($sformatf("trace line %0d dato", s.lineNo), s.expDato, dato);
			// The FSM is still busy in the cycle that reports done
			checkField($sformatf("trace line %0d idle", s.lineNo), 32'd0, 32'(idle));
		end
	endtask

	// Response is registered, so it is checked one cycle after the request
	task automatic runAccess(input traceStep_t s);
		logic [6:0] expFlags;
		logic [6:0] actFlags;
		@(posedge clk);
		ol <= s.ol;
		asid <= s.asid;
		req <= s.req;
		@(posedge clk);
		req.cyc <= 1'b0;
		req.we <= 1'b0;
		req.icl <= 1'b0;
		@(negedge clk);
		expFlags = {s.expResp.cyc, s.expResp.we, s.expResp.miss, s.expResp.rdv,
			s.expResp.wrv, s.expResp.exv, s.expResp.uncached};
		actFlags = {resp.cyc, resp.we, resp.miss, resp.rdv, resp.wrv, resp.exv, resp.uncached};
		checkField($sformatf("trace line %0d padr", s.lineNo), s.expResp.padr, resp.padr);
		checkField($sformatf("trace line %0d flags cyc/we/miss/rdv/wrv/exv/unc", s.lineNo),
			32'(expFlags), 32'(actFlags));
	endtask

	// ==========================================================================
	// Main sequence and watchdog
	// ==========================================================================
	initial
	begin
		rstN = 1'b0;
		ld = 1'b0;
		cmd = '0;
		ol = '0;
		asid = '0;
		req = '0;
		lfsr = 16'd3;
		traceLoaded = 1'b0;
		loadTrace();
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		foreach (steps[i])
		begin
			waitIdleGap();
			if (steps[i].isAccess)
				runAccess(steps[i]);
			else
				runCommand(steps[i]);
		end
		@(posedge clk);
		$display("All tests passed!");
		$finish;
	end

	initial
	begin
		int limitNs;
		wait (traceLoaded);
		limitNs = (resetCycles + steps.size() * stepCycles + 20) * clkPeriod;
		#(limitNs);
		stopOnError($sformatf("Watchdog expired after %0d ns, the run is stuck", limitNs));
	end

endmodule

`default_nettype wire

// File: tlb_trace.txt
# Command: 0 op regno data expected_dato
# Access:  1 ol asid cyc we icl vaddr expected_padr miss rdv wrv exv uncached
# Register readback
0 1 0 00000006 00000002
0 2 0 00000000 00000002
0 1 0 00000000 00000000
0 1 1 80000005 80000001
0 2 1 00000000 80000001
0 1 3 FFF12345 00012345
0 1 4 FFFABCDE 000ABCDE
0 1 5 FFFF5A3F 00005A1F
0 2 3 00000000 00012345
0 2 4 00000000 000ABCDE
0 2 5 00000000 00005A1F
# Passthrough while disabled, then at level 0 and in the unmapped region
1 1 05 1 0 0 12345678 12345678 0 0 0 0 0
0 7 0 00000000 00000000
1 0 05 1 1 0 23456ABC 23456ABC 0 0 0 0 0
1 3 05 1 0 1 F0001234 F0001234 0 0 0 0 0
# Indexed write of page 12345 into way 2, then READ back
0 1 5 00002A07 00002A07
0 1 1 00000002 00000002
0 5 0 00000000 00000000
1 1 2A 1 0 0 12345678 ABCDE678 0 0 0 0 0
1 1 2A 1 1 0 12345ABC ABCDEABC 0 0 0 0 0
0 1 4 00000000 00000000
0 1 5 00000000 00000000
0 4 0 00000000 00000000
0 2 4 00000000 000ABCDE
0 2 5 00000000 00002A07
0 2 3 00000000 00012345
# Misses on a foreign ASID, then a global entry
1 1 33 1 0 0 12345678 FFFFF678 1 0 0 0 0
1 1 33 1 0 0 12355ABC FFFFFABC 1 0 0 0 0
0 2 6 00000000 12345678
0 1 3 00040007 00040007
0 1 4 00077000 00077000
0 1 5 00001317 00001317
0 5 0 00000000 00000000
1 2 99 1 0 0 40007123 77000123 0 0 0 0 0
# Permissions
0 1 3 00050003 00050003
0 1 4 00011111 00011111
0 1 5 00002A0D 00002A0D
0 5 0 00000000 00000000
1 1 2A 1 1 0 50003010 11111010 0 0 1 0 1
1 1 2A 1 0 0 50003020 11111020 0 0 0 0 1
0 1 3 00060004 00060004
0 1 5 00002A02 00002A02
0 5 0 00000000 00000000
1 1 2A 1 0 0 60004000 11111000 0 1 0 0 0
1 1 2A 1 0 1 60004004 11111004 0 0 0 1 0
1 1 2A 1 1 0 60004008 11111008 0 0 0 0 0
# Probe, random write above Wired, invalidate all
0 1 1 00000000 00000000
0 3 0 00000000 00000000
0 2 1 00000000 00000002
0 1 3 00070004 00070004
0 3 0 00000000 00000000
0 2 1 00000000 80000002
0 1 0 00000003 00000003
0 6 0 00000000 00000003
0 3 0 00000000 00000003
0 2 1 00000000 00000003
1 1 2A 1 1 0 70004ABC 11111ABC 0 0 0 0 0
0 9 0 00000000 00000003
1 1 2A 1 0 0 12345678 FFFFF678 1 0 0 0 0
1 1 2A 1 1 0 70004ABC FFFFFABC 1 0 0 0 0
0 2 6 00000000 12345678
